// File: rvdec_top.f
+incdir+design
design/rvdec_pkg.sv
design/rvdec_class_if.sv
design/rvdec_opclass.sv
design/rvdec_reg_idx.sv
design/rvdec_imm_gen.sv
design/rvdec_out_stage.sv
design/rvdec_top.sv
test/rvdec_tb.sv

// File: Makefile
SRCS := $(wildcard design/*.sv design/*.svh) test/rvdec_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vrvdec_tb: rvdec_top.f $(SRCS)
	verilator --binary --timing --assert -f rvdec_top.f --top-module rvdec_tb \
		-Mdir obj_dir -o Vrvdec_tb

sim.log: obj_dir/Vrvdec_tb
	./obj_dir/Vrvdec_tb > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/rvdec_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvdec_cfg.svh"

module rvdec_tb;

  typedef struct {
    rvdec_pkg::unit_e unit;
    logic        rs1en, rs2en, rdwen, jal, jalr, bxx, misalgn, buserr, ilegl;
    logic [4:0]  rs1idx, rs2idx, rdidx;
    logic [31:0] imm, bjp_imm, pc;
    int          due; // cycle count at which o_valid must show it
  } exp_t;

  logic clk = 1'b0;
  logic i_rst_n, i_valid, i_misalgn, i_buserr;
  logic [31:0] i_instr, i_pc;
  logic o_valid, o_rs1en, o_rs2en, o_rdwen, o_jal, o_jalr, o_bxx, o_misalgn, o_buserr, o_ilegl;
  rvdec_pkg::unit_e o_unit;
  logic [4:0]  o_rs1idx, o_rs2idx, o_rdidx;
  logic [31:0] o_imm, o_bjp_imm, o_pc;

  exp_t exp_q[$];
  int cyc = 0;
  int errors = 0;
  int checks = 0;
  integer seed = 32'hb644_1d69;
  logic [31:0] dir_words [30];
  logic [6:0]  kept_ops [11];

  rvdec_top dut_i (
    .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_instr(i_instr), .i_pc(i_pc),
    .i_misalgn(i_misalgn), .i_buserr(i_buserr), .o_valid(o_valid), .o_unit(o_unit),
    .o_rs1en(o_rs1en), .o_rs2en(o_rs2en), .o_rdwen(o_rdwen), .o_rs1idx(o_rs1idx),
    .o_rs2idx(o_rs2idx), .o_rdidx(o_rdidx), .o_imm(o_imm), .o_bjp_imm(o_bjp_imm),
    .o_jal(o_jal), .o_jalr(o_jalr), .o_bxx(o_bxx), .o_pc(o_pc), .o_misalgn(o_misalgn),
    .o_buserr(o_buserr), .o_ilegl(o_ilegl)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic exp_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
                                      input logic mis, input logic berr);
    exp_t e;
    rvdec_pkg::imm_fmt_e fmt;
    logic [2:0] f3;
    logic [6:0] f7;
    logic u1, u2, ud, shamt_ok, bad_shift;
    f3 = w[14:12];
    f7 = w[31:25];
    e.unit = rvdec_pkg::UNIT_NONE;
    fmt = rvdec_pkg::IMM_NONE;
    {u1, u2, ud, bad_shift, e.jal, e.jalr, e.bxx} = '0;
    shamt_ok = (f3 == 3'd1) ? (w[31:26] == 6'h00) :
               (f3 == 3'd5) ? (w[31:26] == 6'h00 || w[31:26] == 6'h10) : 1'b1;
    case (w[6:0])
      7'h03: if (f3 != 3'd3 && f3 < 3'd6) begin
        e.unit = rvdec_pkg::UNIT_AGU;
        fmt = rvdec_pkg::IMM_I;
        u1 = 1'b1;
        ud = 1'b1;
      end
      7'h23: if (f3 <= 3'd2) begin
        e.unit = rvdec_pkg::UNIT_AGU;
        fmt = rvdec_pkg::IMM_S;
        u1 = 1'b1;
        u2 = 1'b1;
      end
      7'h63: if (f3 != 3'd2 && f3 != 3'd3) begin
        e.unit = rvdec_pkg::UNIT_BJP;
        fmt = rvdec_pkg::IMM_B;
        u1 = 1'b1;
        u2 = 1'b1;
        e.bxx = 1'b1;
      end
      7'h67: if (f3 == 3'd0) begin
        e.unit = rvdec_pkg::UNIT_BJP;
        fmt = rvdec_pkg::IMM_I;
        u1 = 1'b1;
        ud = 1'b1;
        e.jalr = 1'b1;
      end
      7'h6f: begin
        e.unit = rvdec_pkg::UNIT_BJP;
        fmt = rvdec_pkg::IMM_J;
        ud = 1'b1;
        e.jal = 1'b1;
      end
      7'h0f: if (f3 <= 3'd1) e.unit = rvdec_pkg::UNIT_BJP; // fence, fence.i
      7'h13: if (shamt_ok) begin
        e.unit = rvdec_pkg::UNIT_ALU;
        fmt = rvdec_pkg::IMM_I;
        u1 = 1'b1;
        ud = 1'b1;
        bad_shift = (f3 == 3'd1 || f3 == 3'd5) && w[25];
      end
      7'h33: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        e.unit = rvdec_pkg::UNIT_ALU;
        u1 = 1'b1;
        u2 = 1'b1;
        ud = 1'b1;
      end
      7'h37, 7'h17: begin
        e.unit = rvdec_pkg::UNIT_ALU;
        fmt = rvdec_pkg::IMM_U;
        ud = 1'b1;
      end
      7'h73: if (f3 == 3'd0) begin
        if (w[31:20] == 12'h302) e.unit = rvdec_pkg::UNIT_BJP; // mret
        else if (w[31:20] == 12'h000 || w[31:20] == 12'h001 || w[31:20] == 12'h105)
          e.unit = rvdec_pkg::UNIT_ALU;
      end else if (f3 != 3'd4) begin
        e.unit = rvdec_pkg::UNIT_CSR;
        ud = 1'b1;
        u1 = ~f3[2]; // zimm forms read nothing
      end
      default: ;
    endcase
    e.rs1idx = w[19:15];
    e.rs2idx = w[24:20];
    e.rdidx  = w[11:7];
    e.rs1en  = u1 && (w[19:15] != 5'd0);
    e.rs2en  = u2 && (w[24:20] != 5'd0);
    e.rdwen  = ud && (w[11:7] != 5'd0);
    case (fmt)
      rvdec_pkg::IMM_I: e.imm = 32'($signed(w[31:20]));
      rvdec_pkg::IMM_S: e.imm = 32'($signed({w[31:25], w[11:7]}));
      rvdec_pkg::IMM_B: e.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      rvdec_pkg::IMM_U: e.imm = {w[31:12], 12'h000};
      rvdec_pkg::IMM_J: e.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default:          e.imm = 32'h0;
    endcase
    e.bjp_imm = (e.jal || e.jalr || e.bxx) ? e.imm : 32'h0;
    e.ilegl = (e.unit == rvdec_pkg::UNIT_NONE) || bad_shift || w == 32'h0 ||
              w == 32'hffff_ffff || (e.rs1en && int'(e.rs1idx) >= `RVDEC_RF_NUM) ||
              (e.rs2en && int'(e.rs2idx) >= `RVDEC_RF_NUM) ||
              (e.rdwen && int'(e.rdidx) >= `RVDEC_RF_NUM);
    e.pc = pc;
    e.misalgn = mis;
    e.buserr = berr;
    e.due = 0;
    return e;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // drives one rising edge and queues the expected decode when valid
  task automatic drive_cycle(input logic v, input logic [31:0] w, input logic [31:0] pc,
                             input logic mis, input logic berr);
    exp_t e;
    @(posedge clk);
    i_valid   <= v;
    i_instr   <= w;
    i_pc      <= pc;
    i_misalgn <= mis;
    i_buserr  <= berr;
    if (v) begin
      e = ref_decode(w, pc, mis, berr);
      e.due = cyc + 2;
      exp_q.push_back(e);
    end
  endtask

  always @(negedge clk) begin : compare
    exp_t e;
    if (i_rst_n) begin
      if (o_valid && exp_q.size() == 0) begin
        errors++;
        $display("error at %0t: o_valid high with no instruction pending", $time);
      end else if (o_valid) begin
        e = exp_q.pop_front();
        check_eq("latency", 32'(cyc), 32'(e.due));
        check_eq("o_unit", 32'(o_unit), 32'(e.unit));
        check_eq("o_rs1en/o_rs2en/o_rdwen", 32'({o_rs1en, o_rs2en, o_rdwen}),
                 32'({e.rs1en, e.rs2en, e.rdwen}));
        check_eq("o_rs1idx", 32'(o_rs1idx), 32'(e.rs1idx));
        check_eq("o_rs2idx", 32'(o_rs2idx), 32'(e.rs2idx));
        check_eq("o_rdidx", 32'(o_rdidx), 32'(e.rdidx));
        check_eq("o_imm", o_imm, e.imm);
        check_eq("o_bjp_imm", o_bjp_imm, e.bjp_imm);
        check_eq("o_jal/o_jalr/o_bxx", 32'({o_jal, o_jalr, o_bxx}), 32'({e.jal, e.jalr, e.bxx}));
        check_eq("o_pc", o_pc, e.pc);
        check_eq("o_misalgn/o_buserr", 32'({o_misalgn, o_buserr}), 32'({e.misalgn, e.buserr}));
        check_eq("o_ilegl", 32'(o_ilegl), 32'(e.ilegl));
      end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
        errors++;
        $display("error at %0t: no o_valid for instruction at pc %h", $time, exp_q[0].pc);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin : stim
    logic [31:0] r, w;
    int t;
    dir_words = '{32'h00500093, 32'hfff30293, 32'h00812183, 32'hfe412e23, 32'hfe208ce3,
                  32'hffdff0ef, 32'h00008067, 32'h12345537, 32'hfffff597, 32'h002081b3,
                  32'h402081b3, 32'h00309093, 32'h40415113, 32'h02009093, 32'h0ff0000f,
                  32'h0000100f, 32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073,
                  32'h300110f3, 32'h3001e2f3, 32'h300a50f3, 32'h00208a33, 32'h0008a183,
                  32'h00000000, 32'hffffffff, 32'h0000005b, 32'h022081b3, 32'h0020a063};
    kept_ops = '{7'h03, 7'h23, 7'h63, 7'h67, 7'h6f, 7'h0f, 7'h13, 7'h33, 7'h37, 7'h17, 7'h73};
    i_rst_n   = 1'b0;
    i_valid   = 1'b0;
    i_instr   = 32'h0;
    i_pc      = 32'h0;
    i_misalgn = 1'b0;
    i_buserr  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_eq("reset flags", 32'({o_valid, o_rs1en, o_rs2en, o_rdwen, o_jal, o_jalr, o_bxx,
                                 o_misalgn, o_buserr, o_ilegl}), 32'h0);
    check_eq("reset o_unit/o_rs1idx/o_rs2idx/o_rdidx",
             32'({o_unit, o_rs1idx, o_rs2idx, o_rdidx}), 32'h0);
    check_eq("reset o_imm", o_imm, 32'h0);
    check_eq("reset o_bjp_imm", o_bjp_imm, 32'h0);
    check_eq("reset o_pc", o_pc, 32'h0);
    @(posedge clk);
    i_rst_n <= 1'b1;
    for (int i = 0; i < 30; i++) begin
      drive_cycle(1'b1, dir_words[i], 32'h8000_0000 + 32'(4 * i), i[2], i[3]);
      if (i % 7 == 6) drive_cycle(1'b0, 32'hdead_beef, 32'h0, 1'b1, 1'b1);
    end
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      w = $random(seed);
      if (r[8]) w[6:0] = kept_ops[r[31:16] % 16'd11]; // bias toward kept opcodes
      drive_cycle(r[0] | r[1], w, {r[31:2], 2'b00}, r[4], r[5]);
    end
    drive_cycle(1'b0, 32'h0, 32'h0, 1'b0, 1'b0);
    t = 0;
    while (exp_q.size() != 0 && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("error: %0d instructions never came out of the decoder", exp_q.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/rvdec_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvdec_cfg.svh"

module rvdec_top (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_valid,
  input  logic [`RVDEC_XLEN-1:0]        i_instr,
  input  logic [`RVDEC_PC_SIZE-1:0]     i_pc,
  input  logic                          i_misalgn,
  input  logic                          i_buserr,
  output logic                          o_valid,
  output rvdec_pkg::unit_e              o_unit,
  output logic                          o_rs1en,
  output logic                          o_rs2en,
  output logic                          o_rdwen,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs1idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs2idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rdidx,
  output logic [`RVDEC_XLEN-1:0]        o_imm,
  output logic [`RVDEC_XLEN-1:0]        o_bjp_imm,
  output logic                          o_jal,
  output logic                          o_jalr,
  output logic                          o_bxx,
  output logic [`RVDEC_PC_SIZE-1:0]     o_pc,
  output logic                          o_misalgn,
  output logic                          o_buserr,
  output logic                          o_ilegl
);

  logic                          dec_rs1en;
  logic                          dec_rs2en;
  logic                          dec_rdwen;
  logic [`RVDEC_RFIDX_WIDTH-1:0] dec_rs1idx;
  logic [`RVDEC_RFIDX_WIDTH-1:0] dec_rs2idx;
  logic [`RVDEC_RFIDX_WIDTH-1:0] dec_rdidx;
  logic                          dec_idx_ilegl;
  logic [`RVDEC_XLEN-1:0]        dec_imm;
  logic [`RVDEC_XLEN-1:0]        dec_bjp_imm;

  rvdec_class_if u_cls ();

  rvdec_opclass u_opclass (.i_instr(i_instr), .cls(u_cls.producer));

  rvdec_reg_idx u_reg_idx (
    .i_instr(i_instr), .cls(u_cls.consumer),
    .o_rs1en(dec_rs1en), .o_rs2en(dec_rs2en), .o_rdwen(dec_rdwen),
    .o_rs1idx(dec_rs1idx), .o_rs2idx(dec_rs2idx), .o_rdidx(dec_rdidx),
    .o_idx_ilegl(dec_idx_ilegl)
  );

  rvdec_imm_gen u_imm_gen (
    .i_instr(i_instr), .cls(u_cls.consumer),
    .o_imm(dec_imm), .o_bjp_imm(dec_bjp_imm)
  );

  // single decode pipeline register
  rvdec_out_stage u_out_stage (
    .clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .cls(u_cls.consumer),
    .i_rs1en(dec_rs1en), .i_rs2en(dec_rs2en), .i_rdwen(dec_rdwen),
    .i_rs1idx(dec_rs1idx), .i_rs2idx(dec_rs2idx), .i_rdidx(dec_rdidx),
    .i_idx_ilegl(dec_idx_ilegl), .i_imm(dec_imm), .i_bjp_imm(dec_bjp_imm),
    .i_pc(i_pc), .i_misalgn(i_misalgn), .i_buserr(i_buserr),
    .o_valid(o_valid), .o_unit(o_unit),
    .o_rs1en(o_rs1en), .o_rs2en(o_rs2en), .o_rdwen(o_rdwen),
    .o_rs1idx(o_rs1idx), .o_rs2idx(o_rs2idx), .o_rdidx(o_rdidx),
    .o_imm(o_imm), .o_bjp_imm(o_bjp_imm),
    .o_jal(o_jal), .o_jalr(o_jalr), .o_bxx(o_bxx),
    .o_pc(o_pc), .o_misalgn(o_misalgn), .o_buserr(o_buserr),
    .o_ilegl(o_ilegl)
  );

endmodule

`default_nettype wire

// File: design/rvdec_out_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvdec_cfg.svh"

module rvdec_out_stage (
  input  logic                          clk,
  input  logic                          i_rst_n,
  input  logic                          i_valid,
  rvdec_class_if.consumer               cls,
  input  logic                          i_rs1en,
  input  logic                          i_rs2en,
  input  logic                          i_rdwen,
  input  logic [`RVDEC_RFIDX_WIDTH-1:0] i_rs1idx,
  input  logic [`RVDEC_RFIDX_WIDTH-1:0] i_rs2idx,
  input  logic [`RVDEC_RFIDX_WIDTH-1:0] i_rdidx,
  input  logic                          i_idx_ilegl,
  input  logic [`RVDEC_XLEN-1:0]        i_imm,
  input  logic [`RVDEC_XLEN-1:0]        i_bjp_imm,
  input  logic [`RVDEC_PC_SIZE-1:0]     i_pc,
  input  logic                          i_misalgn,
  input  logic                          i_buserr,
  output logic                          o_valid,
  output rvdec_pkg::unit_e              o_unit,
  output logic                          o_rs1en,
  output logic                          o_rs2en,
  output logic                          o_rdwen,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs1idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs2idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rdidx,
  output logic [`RVDEC_XLEN-1:0]        o_imm,
  output logic [`RVDEC_XLEN-1:0]        o_bjp_imm,
  output logic                          o_jal,
  output logic                          o_jalr,
  output logic                          o_bxx,
  output logic [`RVDEC_PC_SIZE-1:0]     o_pc,
  output logic                          o_misalgn,
  output logic                          o_buserr,
  output logic                          o_ilegl
);

  // plain strobe without back-pressure
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) o_valid <= 1'b0;
    else          o_valid <= i_valid;
  end

  // payload holds while idle
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_unit    <= rvdec_pkg::UNIT_NONE;
      o_rs1en   <= 1'b0;
      o_rs2en   <= 1'b0;
      o_rdwen   <= 1'b0;
      o_rs1idx  <= '0;
      o_rs2idx  <= '0;
      o_rdidx   <= '0;
      o_imm     <= '0;
      o_bjp_imm <= '0;
      o_jal     <= 1'b0;
      o_jalr    <= 1'b0;
      o_bxx     <= 1'b0;
      o_pc      <= '0;
      o_misalgn <= 1'b0;
      o_buserr  <= 1'b0;
      o_ilegl   <= 1'b0;
    end else if (i_valid) begin
      o_unit    <= cls.unit;
      o_rs1en   <= i_rs1en;
      o_rs2en   <= i_rs2en;
      o_rdwen   <= i_rdwen;
      o_rs1idx  <= i_rs1idx;
      o_rs2idx  <= i_rs2idx;
      o_rdidx   <= i_rdidx;
      o_imm     <= i_imm;
      o_bjp_imm <= i_bjp_imm;
      o_jal     <= cls.jal;
      o_jalr    <= cls.jalr;
      o_bxx     <= cls.bxx;
      o_pc      <= i_pc;
      o_misalgn <= i_misalgn;
      o_buserr  <= i_buserr;
      o_ilegl   <= cls.op_ilegl | i_idx_ilegl; // opcode or register range
    end
  end

  a_legal_idx_range: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_valid && !o_ilegl) |-> ((!o_rdwen || (int'(o_rdidx) < `RVDEC_RF_NUM)) &&
                               (!o_rs1en || (int'(o_rs1idx) < `RVDEC_RF_NUM)) &&
                               (!o_rs2en || (int'(o_rs2idx) < `RVDEC_RF_NUM))))
    else $error("out of range register index passed as legal");

endmodule

`default_nettype wire

// File: design/rvdec_imm_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvdec_cfg.svh"

module rvdec_imm_gen (
  input  logic [31:0]            i_instr,
  rvdec_class_if.consumer        cls,
  output logic [`RVDEC_XLEN-1:0] o_imm,
  output logic [`RVDEC_XLEN-1:0] o_bjp_imm
);

  localparam int XL = `RVDEC_XLEN;

  logic [XL-1:0] imm_i;
  logic [XL-1:0] imm_s;
  logic [XL-1:0] imm_b;
  logic [XL-1:0] imm_u;
  logic [XL-1:0] imm_j;

  assign imm_i = {{(XL-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{(XL-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{(XL-13){i_instr[31]}}, i_instr[31], i_instr[7],
                  i_instr[30:25], i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0}; // upper 20 bits need no extension on rv32
  assign imm_j = {{(XL-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                  i_instr[20], i_instr[30:21], 1'b0};

  always_comb begin
    case (cls.imm_fmt)
      rvdec_pkg::IMM_I: o_imm = imm_i;
      rvdec_pkg::IMM_S: o_imm = imm_s;
      rvdec_pkg::IMM_B: o_imm = imm_b;
      rvdec_pkg::IMM_U: o_imm = imm_u;
      rvdec_pkg::IMM_J: o_imm = imm_j;
      default:          o_imm = '0;
    endcase
  end

  // target offset for the bjp unit
  always_comb begin
    if (cls.jal) begin
      o_bjp_imm = imm_j;
    end else if (cls.jalr) begin
      o_bjp_imm = imm_i;
    end else if (cls.bxx) begin
      o_bjp_imm = imm_b;
    end else begin
      o_bjp_imm = '0;
    end
  end

  // format chosen by the classifier must agree with the jump flags
  always_comb begin
    assert final (!(cls.jal || cls.jalr || cls.bxx) || (o_bjp_imm == o_imm))
      else $error("jump target offset differs from the selected immediate");
  end

endmodule

`default_nettype wire

// File: design/rvdec_reg_idx.sv
`default_nettype none
`timescale 1ns/1ps

`include "rvdec_cfg.svh"

module rvdec_reg_idx (
  input  logic [31:0]                   i_instr,
  rvdec_class_if.consumer               cls,
  output logic                          o_rs1en,
  output logic                          o_rs2en,
  output logic                          o_rdwen,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs1idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rs2idx,
  output logic [`RVDEC_RFIDX_WIDTH-1:0] o_rdidx,
  output logic                          o_idx_ilegl
);

  localparam int unsigned IW = `RVDEC_RFIDX_WIDTH;

  logic rs1_hi, rs2_hi, rd_hi;

  assign o_rs1idx = i_instr[15 +: IW];
  assign o_rs2idx = i_instr[20 +: IW];
  assign o_rdidx  = i_instr[7 +: IW];

  // x0 reads and writes are dropped
  assign o_rs1en = cls.use_rs1 & (|o_rs1idx);
  assign o_rs2en = cls.use_rs2 & (|o_rs2idx);
  assign o_rdwen = cls.use_rd & (|o_rdidx);

  // never fires with a full 32 entry file
  assign rs1_hi = (int'(o_rs1idx) >= `RVDEC_RF_NUM);
  assign rs2_hi = (int'(o_rs2idx) >= `RVDEC_RF_NUM);
  assign rd_hi  = (int'(o_rdidx) >= `RVDEC_RF_NUM);

  assign o_idx_ilegl = (o_rs1en & rs1_hi) | (o_rs2en & rs2_hi) | (o_rdwen & rd_hi);

  // every rv32i format with rs2 also has rs1
  always_comb begin
    assert final (!cls.use_rs2 || cls.use_rs1)
      else $error("rs2 read without rs1 for instruction %h", i_instr);
  end

endmodule

`default_nettype wire

// File: design/rvdec_opclass.sv
`default_nettype none
`timescale 1ns/1ps

module rvdec_opclass (
  input  logic [31:0]     i_instr,
  rvdec_class_if.producer cls
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] sys_fld;

  logic op_load, op_store, op_branch, op_jalr, op_jal, op_miscmem;
  logic op_opimm, op_op, op_system, op_auipc, op_lui;
  logic load_ok, store_ok, branch_ok, jalr_ok, fence_ok;
  logic is_shift, shift_ok, opimm_ok, op_ok, sxxi_ilgl;
  logic sys_f0, ecall, ebreak, mret, wfi, csr_reg, csr_imm;
  logic all0s, all1s;

  assign opcode  = i_instr[6:0];
  assign funct3  = i_instr[14:12];
  assign funct7  = i_instr[31:25];
  assign sys_fld = i_instr[31:20];

  // full 7-bit compare so 16-bit encodings never match
  assign op_load    = (opcode == 7'b0000011);
  assign op_store   = (opcode == 7'b0100011);
  assign op_branch  = (opcode == 7'b1100011);
  assign op_jalr    = (opcode == 7'b1100111);
  assign op_jal     = (opcode == 7'b1101111);
  assign op_miscmem = (opcode == 7'b0001111);
  assign op_opimm   = (opcode == 7'b0010011);
  assign op_op      = (opcode == 7'b0110011);
  assign op_system  = (opcode == 7'b1110011);
  assign op_auipc   = (opcode == 7'b0010111);
  assign op_lui     = (opcode == 7'b0110111);

  assign load_ok   = op_load & (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  assign store_ok  = op_store & (funct3 inside {3'b000, 3'b001, 3'b010});
  assign branch_ok = op_branch & ~(funct3 inside {3'b010, 3'b011});
  assign jalr_ok   = op_jalr & (funct3 == 3'b000);
  assign fence_ok  = op_miscmem & (funct3 inside {3'b000, 3'b001}); // fence, fence.i

  // top imm bits are fixed for slli / srli / srai
  assign is_shift = (funct3 == 3'b001) | (funct3 == 3'b101);
  assign shift_ok = ((funct3 == 3'b001) & (i_instr[31:26] == 6'b000000)) |
                    ((funct3 == 3'b101) & ((i_instr[31:26] == 6'b000000) |
                                           (i_instr[31:26] == 6'b010000)));
  assign opimm_ok  = op_opimm & (~is_shift | shift_ok);
  assign sxxi_ilgl = op_opimm & is_shift & shift_ok & i_instr[25]; // shamt[5] on rv32

  assign op_ok = op_op & ((funct7 == 7'b0000000) |
                          ((funct7 == 7'b0100000) & ((funct3 == 3'b000) | (funct3 == 3'b101))));

  assign sys_f0  = op_system & (funct3 == 3'b000);
  assign ecall   = sys_f0 & (sys_fld == 12'h000);
  assign ebreak  = sys_f0 & (sys_fld == 12'h001);
  assign mret    = sys_f0 & (sys_fld == 12'h302);
  assign wfi     = sys_f0 & (sys_fld == 12'h105);
  assign csr_reg = op_system & (funct3 inside {3'b001, 3'b010, 3'b011});
  assign csr_imm = op_system & (funct3 inside {3'b101, 3'b110, 3'b111}); // zimm in rs1 slot

  always_comb begin
    cls.unit = rvdec_pkg::UNIT_NONE;
    if (load_ok | store_ok) begin
      cls.unit = rvdec_pkg::UNIT_AGU;
    end else if (op_jal | jalr_ok | branch_ok | mret | fence_ok) begin
      cls.unit = rvdec_pkg::UNIT_BJP;
    end else if (csr_reg | csr_imm) begin
      cls.unit = rvdec_pkg::UNIT_CSR;
    end else if (opimm_ok | op_ok | op_auipc | op_lui | ecall | ebreak | wfi) begin
      cls.unit = rvdec_pkg::UNIT_ALU;
    end
  end

  always_comb begin
    cls.imm_fmt = rvdec_pkg::IMM_NONE;
    if (opimm_ok | jalr_ok | load_ok)   cls.imm_fmt = rvdec_pkg::IMM_I;
    else if (store_ok)                  cls.imm_fmt = rvdec_pkg::IMM_S;
    else if (branch_ok)                 cls.imm_fmt = rvdec_pkg::IMM_B;
    else if (op_lui | op_auipc)         cls.imm_fmt = rvdec_pkg::IMM_U;
    else if (op_jal)                    cls.imm_fmt = rvdec_pkg::IMM_J;
  end

  assign cls.use_rs1 = jalr_ok | branch_ok | load_ok | store_ok | opimm_ok | op_ok | csr_reg;
  assign cls.use_rs2 = branch_ok | store_ok | op_ok;
  assign cls.use_rd  = op_lui | op_auipc | op_jal | jalr_ok | load_ok | opimm_ok | op_ok |
                       csr_reg | csr_imm;

  assign cls.jal  = op_jal;
  assign cls.jalr = jalr_ok;
  assign cls.bxx  = branch_ok;

  assign all0s = (i_instr == 32'h0000_0000);
  assign all1s = (i_instr == 32'hffff_ffff);

  assign cls.op_ilegl = (cls.unit == rvdec_pkg::UNIT_NONE) | sxxi_ilgl | all0s | all1s;

  // no operands or immediate for an unclassified word
  always_comb begin
    assert final ((cls.unit != rvdec_pkg::UNIT_NONE) ||
                  ((cls.imm_fmt == rvdec_pkg::IMM_NONE) &&
                   !cls.use_rs1 && !cls.use_rs2 && !cls.use_rd))
      else $error("unclassified instruction %h still selects operands", i_instr);
  end

endmodule

`default_nettype wire

// File: design/rvdec_class_if.sv
`default_nettype none
`timescale 1ns/1ps

// instruction classification shared by the decode blocks
interface rvdec_class_if;

  rvdec_pkg::unit_e    unit;
  rvdec_pkg::imm_fmt_e imm_fmt;

  logic use_rs1;
  logic use_rs2;
  logic use_rd;

  logic jal;
  logic jalr;
  logic bxx;
  logic op_ilegl; // opcode level only

  modport producer (
    output unit, imm_fmt, use_rs1, use_rs2, use_rd, jal, jalr, bxx, op_ilegl
  );

  modport consumer (
    input unit, imm_fmt, use_rs1, use_rs2, use_rd, jal, jalr, bxx, op_ilegl
  );

endinterface

`default_nettype wire

// File: design/rvdec_pkg.sv
`default_nettype none

package rvdec_pkg;

  // execution unit an instruction is dispatched to
  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_ALU  = 3'd1,
    UNIT_AGU  = 3'd2, // loads and stores
    UNIT_BJP  = 3'd3, // branches, jumps, mret, fences
    UNIT_CSR  = 3'd4
  } unit_e;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_e;

endpackage

`default_nettype wire

// File: design/rvdec_cfg.svh
`ifndef RVDEC_CFG_SVH
`define RVDEC_CFG_SVH

// datapath and pc widths
`define RVDEC_XLEN        32
`define RVDEC_PC_SIZE     32

`define RVDEC_RFIDX_WIDTH 5

// implemented integer registers, 32 means full rv32i
`define RVDEC_RF_NUM      16

`endif
